/* hwce_lite.f */
src/hwce_pkg.sv
src/hwce_stream_fifo.sv
src/hwce_stream_source.sv
src/hwce_stream_sink.sv
src/hwce_cfg_slave.sv
src/hwce_job_fsm.sv
src/hwce_top.sv
test/tb_tcdm_mem.sv
test/tb_hwce_top.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f hwce_lite.f --top-module tb_hwce_top -o sim_hwce || exit 1
out=$(./obj_dir/sim_hwce)
echo "$out"
echo "$out" | grep -qF '** PASS **' && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* test/tb_hwce_top.sv */
// hwce_lite testbench
// loopback engine model, memory model, register and job checks with watchdog
`timescale 1ns/10ps

module tb_hwce_top import hwce_pkg::*; ();

  localparam word_t XOR_K = 32'ha5a5_0000;
  // 15 jobs of at most 12 words, 200 cycles per word
  localparam int WATCHDOG_CYCLES = 15 * 12 * 200;

  logic clk_gated = 1'b0;
  logic rst_n;
  logic cfg_req_i, cfg_type_i, cfg_gnt_o, cfg_r_valid_o;
  addr_t cfg_add_i;
  word_t cfg_data_i, cfg_r_data_o;
  logic [ID_W-1:0] cfg_id_i, cfg_r_id_o;
  logic src_req_o, src_gnt_i, src_r_valid_i, snk_req_o, snk_gnt_i;
  addr_t src_add_o, snk_add_o;
  word_t src_r_data_i, snk_data_o, src_tdata_o, snk_tdata_i;
  logic src_tvalid_o, src_tlast_o, src_tready_i;
  logic snk_tvalid_i, snk_tlast_i, snk_tready_o, evt_interrupt_o, hwce_working_o;
  logic src_gnt_en, snk_gnt_en, bd_we;
  logic [7:0] bd_addr;
  word_t bd_data, bd_rdata;

  logic [31:0] rng = 32'h5e3a_95c4;
  int err_cnt = 0;
  int check_cnt = 0;
  int test_cnt = 0;
  int err_base = 0;
  // engine model state
  word_t eng_q[$];
  word_t src_word;
  int eng_len = 1;
  int eng_beat = 0;
  int src_beat = 0;
  logic eng_corrupt = 1'b0;
  logic stress = 1'b0;
  logic src_fire, snk_fire;
  int evt_cnt = 0;
  logic work_low_seen = 1'b0;

  always #20 clk_gated = ~clk_gated;

  hwce_top hwce_top_inst (.*);

  tb_tcdm_mem tcdm_inst (
    .clk_gated(clk_gated), .rst_n(rst_n),
    .src_req_i(src_req_o), .src_add_i(src_add_o), .src_gnt_en_i(src_gnt_en),
    .src_gnt_o(src_gnt_i), .src_r_data_o(src_r_data_i), .src_r_valid_o(src_r_valid_i),
    .snk_req_i(snk_req_o), .snk_add_i(snk_add_o), .snk_data_i(snk_data_o),
    .snk_gnt_en_i(snk_gnt_en), .snk_gnt_o(snk_gnt_i),
    .bd_we_i(bd_we), .bd_addr_i(bd_addr), .bd_data_i(bd_data), .bd_rdata_o(bd_rdata)
  );

  // xorshift32
  function automatic logic [31:0] rnd();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check_equal(input string what, input word_t got, input word_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("error: %0t ns %s: got %h expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    $display("test %-14s %0d errors", name, err_cnt - err_base);
    err_base = err_cnt;
    test_cnt++;
  endtask

  // one config access, response due the very next cycle
  task automatic cfg_rw(input logic wr, input logic [2:0] sel, input word_t wdata,
                        output word_t rdata);
    logic [15:0] id;
    id = rnd() >> 16;
    @(negedge clk_gated);
    check_equal("idle response valid", 32'(cfg_r_valid_o), 32'd0);
    cfg_req_i  = 1'b1;
    cfg_type_i = ~wr;
    cfg_add_i  = addr_t'({sel, 2'b00});
    cfg_data_i = wdata;
    cfg_id_i   = id;
    @(negedge clk_gated);
    check_equal("config grant", 32'(cfg_gnt_o), 32'd1);
    cfg_req_i = 1'b0;
    check_equal("response valid", 32'(cfg_r_valid_o), 32'd1);
    check_equal("response id", 32'(cfg_r_id_o), 32'(id));
    if (wr) check_equal("write response data", cfg_r_data_o, 32'd0);
    rdata = cfg_r_data_o;
  endtask

  task automatic poke(input int idx, input word_t d);
    @(negedge clk_gated);
    bd_we   = 1'b1;
    bd_addr = idx[7:0];
    bd_data = d;
    @(negedge clk_gated);
    bd_we = 1'b0;
  endtask

  task automatic run_job(input int len, input logic corrupt, input logic busy_writes);
    word_t src_img[12];
    word_t r;
    int sb, db, cyc;
    int evt_base;
    sb = int'(rnd() % 32) + 16;
    db = int'(rnd() % 48) + 128;
    for (int i = 0; i < len; i++) begin
      src_img[i] = rnd();
      poke(sb + i, src_img[i]);
    end
    // guard word past the end catches extra writes
    for (int i = 0; i <= len; i++) poke(db + i, 32'hdead_0000 ^ word_t'(db + i));
    cfg_rw(1'b1, REG_SRC_ADDR, word_t'(sb * 4), r);
    cfg_rw(1'b1, REG_DST_ADDR, word_t'(db * 4), r);
    cfg_rw(1'b1, REG_LEN, word_t'(len), r);
    eng_len     = len;
    eng_corrupt = corrupt;
    evt_base    = evt_cnt;
    cfg_rw(1'b1, REG_TRIGGER, 32'd0, r);
    @(negedge clk_gated);
    cfg_rw(1'b0, REG_STATUS, 32'd0, r);
    check_equal("busy during job", 32'(r[0]), 32'd1);
    check_equal("working during job", 32'(hwce_working_o), 32'd1);
    if (busy_writes) begin
      cfg_rw(1'b1, REG_SRC_ADDR, rnd(), r);
      cfg_rw(1'b1, REG_DST_ADDR, rnd(), r);
      cfg_rw(1'b1, REG_LEN, rnd(), r);
      cfg_rw(1'b1, REG_TRIGGER, 32'd0, r);
    end
    cyc = 0;
    while (evt_cnt == evt_base && cyc < 200 * len + 200) begin
      @(negedge clk_gated);
      cyc++;
    end
    if (evt_cnt == evt_base) begin
      $display("timeout: job of %0d words raised no end-of-job event", len);
      err_cnt++;
    end
    repeat (30) @(negedge clk_gated);
    check_equal("events per job", word_t'(evt_cnt - evt_base), 32'd1);
    // clock gate closes again once idle
    check_equal("working after job", 32'(hwce_working_o), 32'd0);
    cfg_rw(1'b0, REG_STATUS, 32'd0, r);
    check_equal("status after job", r, word_t'({corrupt, 1'b0}));
    cfg_rw(1'b0, REG_SRC_ADDR, 32'd0, r);
    check_equal("src readback", r, word_t'(sb * 4));
    cfg_rw(1'b0, REG_DST_ADDR, 32'd0, r);
    check_equal("dst readback", r, word_t'(db * 4));
    cfg_rw(1'b0, REG_LEN, 32'd0, r);
    check_equal("len readback", r, word_t'(len));
    for (int i = 0; i <= len; i++) begin
      bd_addr = 8'(db + i);
      #1;
      if (i < len) check_equal("result word", bd_rdata, src_img[i] ^ XOR_K);
      else check_equal("guard word", bd_rdata, 32'hdead_0000 ^ word_t'(db + i));
    end
  endtask

  // engine loopback, inputs change on the falling edge only
  initial begin
    src_tready_i = 1'b0;
    snk_tvalid_i = 1'b0;
    snk_tdata_i  = '0;
    snk_tlast_i  = 1'b0;
    src_gnt_en   = 1'b0;
    snk_gnt_en   = 1'b0;
    src_fire     = 1'b0;
    snk_fire     = 1'b0;
    forever begin
      logic [31:0] r;
      @(negedge clk_gated);
      r = rnd();
      // transfers that happened on the last rising edge
      if (src_fire) begin
        eng_q.push_back(src_word ^ XOR_K);
        src_beat = (src_beat == eng_len - 1) ? 0 : src_beat + 1;
      end
      if (snk_fire) begin
        void'(eng_q.pop_front());
        eng_beat = (eng_beat == eng_len - 1) ? 0 : eng_beat + 1;
      end
      src_gnt_en   = ~stress | r[2];
      snk_gnt_en   = ~stress | r[3];
      src_tready_i = ~stress | r[0] | r[1];
      // valid held until taken
      if (!(snk_tvalid_i && !snk_fire))
        snk_tvalid_i = (eng_q.size() > 0) && (!stress || r[5:4] != 2'b00);
      snk_tdata_i = (eng_q.size() > 0) ? eng_q[0] : '0;
      snk_tlast_i = eng_corrupt ? (eng_beat == eng_len - 2) : (eng_beat == eng_len - 1);
      #1;
      src_fire = src_tvalid_o & src_tready_i;
      src_word = src_tdata_o;
      snk_fire = snk_tvalid_i & snk_tready_o;
      // source tlast only on word LEN-1
      if (src_fire)
        check_equal("source tlast", 32'(src_tlast_o), 32'(src_beat == eng_len - 1));
    end
  end

  always @(negedge clk_gated) begin
    if (evt_interrupt_o) begin
      evt_cnt++;
      if (!hwce_working_o) work_low_seen = 1'b1;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_gated);
    $display("watchdog expired, the tests did not complete in time");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    word_t r;
    word_t v;
    rst_n      = 1'b0;
    cfg_req_i  = 1'b0;
    cfg_type_i = 1'b0;
    cfg_add_i  = '0;
    cfg_data_i = '0;
    cfg_id_i   = '0;
    bd_we      = 1'b0;
    bd_addr    = '0;
    bd_data    = '0;
    repeat (10) @(posedge clk_gated);
    @(negedge clk_gated);
    rst_n = 1'b1;

    cfg_rw(1'b0, REG_STATUS, 32'd0, r);
    check_equal("status after reset", r, 32'd0);
    v = rnd();
    cfg_rw(1'b1, REG_SRC_ADDR, v, r);
    cfg_rw(1'b0, REG_SRC_ADDR, 32'd0, r);
    check_equal("src readback", r, v);
    v = rnd();
    cfg_rw(1'b1, REG_DST_ADDR, v, r);
    cfg_rw(1'b0, REG_DST_ADDR, 32'd0, r);
    check_equal("dst readback", r, v);
    v = rnd();
    cfg_rw(1'b1, REG_LEN, v, r);
    cfg_rw(1'b0, REG_LEN, 32'd0, r);
    check_equal("len readback", r, {16'h0, v[15:0]});
    cfg_rw(1'b0, REG_TRIGGER, 32'd0, r);
    check_equal("trigger readback", r, 32'd0);
    end_test("readback");

    for (int j = 0; j < 6; j++) run_job(int'(rnd() % 12) + 1, 1'b0, 1'b0);
    check_equal("working at event", 32'(work_low_seen), 32'd0);
    end_test("job_result");

    stress = 1'b1;
    for (int j = 0; j < 6; j++) run_job(int'(rnd() % 12) + 1, 1'b0, 1'b0);
    end_test("back_pressure");

    run_job(int'(rnd() % 11) + 2, 1'b1, 1'b0);
    run_job(int'(rnd() % 12) + 1, 1'b0, 1'b0);
    end_test("framing");

    run_job(12, 1'b0, 1'b1);
    check_equal("working at event", 32'(work_low_seen), 32'd0);
    end_test("busy_writes");

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* test/tb_tcdm_mem.sv */
// cluster memory model for the hwce_lite testbench
// read port and write port with external grant enables, one-cycle read response
`timescale 1ns/10ps

module tb_tcdm_mem import hwce_pkg::*; (
  input  logic       clk_gated,
  input  logic       rst_n,
  // read port
  input  logic       src_req_i,
  input  addr_t      src_add_i,
  input  logic       src_gnt_en_i,
  output logic       src_gnt_o,
  output word_t      src_r_data_o,
  output logic       src_r_valid_o,
  // write port
  input  logic       snk_req_i,
  input  addr_t      snk_add_i,
  input  word_t      snk_data_i,
  input  logic       snk_gnt_en_i,
  output logic       snk_gnt_o,
  // backdoor for preload and result check
  input  logic       bd_we_i,
  input  logic [7:0] bd_addr_i,
  input  word_t      bd_data_i,
  output word_t      bd_rdata_o
);

  word_t mem [256];

  // grants come and go regardless of req
  assign src_gnt_o  = src_gnt_en_i;
  assign snk_gnt_o  = snk_gnt_en_i;
  assign bd_rdata_o = mem[bd_addr_i];

  always_ff @(posedge clk_gated) begin
    if (bd_we_i) mem[bd_addr_i] <= bd_data_i;
    if (snk_req_i && snk_gnt_o) mem[snk_add_i[9:2]] <= snk_data_i;
  end

  // read answer exactly one cycle after the grant
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      src_r_valid_o <= 1'b0;
      src_r_data_o  <= '0;
    end else begin
      src_r_valid_o <= src_req_i & src_gnt_o;
      if (src_req_i && src_gnt_o) src_r_data_o <= mem[src_add_i[9:2]];
    end
  end

endmodule

/* src/hwce_top.sv */
// hwce_lite top level
// config slave, job sequencer, one source and one sink stream
`timescale 1ns/10ps

module hwce_top import hwce_pkg::*; (
  input  logic            clk_gated,
  input  logic            rst_n,
  // config port
  input  logic            cfg_req_i,
  input  addr_t           cfg_add_i,
  input  logic            cfg_type_i,
  input  word_t           cfg_data_i,
  input  logic [ID_W-1:0] cfg_id_i,
  output logic            cfg_gnt_o,
  output logic            cfg_r_valid_o,
  output word_t           cfg_r_data_o,
  output logic [ID_W-1:0] cfg_r_id_o,
  // source memory port
  output logic            src_req_o,
  output addr_t           src_add_o,
  input  logic            src_gnt_i,
  input  word_t           src_r_data_i,
  input  logic            src_r_valid_i,
  // sink memory port, write only
  output logic            snk_req_o,
  output addr_t           snk_add_o,
  output word_t           snk_data_o,
  input  logic            snk_gnt_i,
  // stream towards the engine
  output logic            src_tvalid_o,
  output word_t           src_tdata_o,
  output logic            src_tlast_o,
  input  logic            src_tready_i,
  // stream from the engine
  input  logic            snk_tvalid_i,
  input  word_t           snk_tdata_i,
  input  logic            snk_tlast_i,
  output logic            snk_tready_o,
  output logic            evt_interrupt_o,
  output logic            hwce_working_o
);

  logic  job_start;
  logic  job_done;
  logic  busy;
  logic  stream_start;
  logic  src_done;
  logic  snk_done;
  logic  frame_err;
  addr_t src_addr;
  addr_t dst_addr;
  len_t  len;

  hwce_cfg_slave cfg_slave_inst (
    .clk_gated       ( clk_gated       ),
    .rst_n           ( rst_n           ),
    .cfg_req_i       ( cfg_req_i       ),
    .cfg_add_i       ( cfg_add_i       ),
    .cfg_type_i      ( cfg_type_i      ),
    .cfg_data_i      ( cfg_data_i      ),
    .cfg_id_i        ( cfg_id_i        ),
    .cfg_gnt_o       ( cfg_gnt_o       ),
    .cfg_r_valid_o   ( cfg_r_valid_o   ),
    .cfg_r_data_o    ( cfg_r_data_o    ),
    .cfg_r_id_o      ( cfg_r_id_o      ),
    .busy_i          ( busy            ),
    .job_done_i      ( job_done        ),
    .frame_err_i     ( frame_err       ),
    .job_start_o     ( job_start       ),
    .src_addr_o      ( src_addr        ),
    .dst_addr_o      ( dst_addr        ),
    .len_o           ( len             ),
    .evt_interrupt_o ( evt_interrupt_o )
  );

  hwce_job_fsm job_fsm_inst (
    .clk_gated      ( clk_gated      ),
    .rst_n          ( rst_n          ),
    .job_start_i    ( job_start      ),
    .src_done_i     ( src_done       ),
    .snk_done_i     ( snk_done       ),
    .stream_start_o ( stream_start   ),
    .busy_o         ( busy           ),
    .working_o      ( hwce_working_o ),
    .job_done_o     ( job_done       )
  );

  hwce_stream_source source_inst (
    .clk_gated   ( clk_gated     ),
    .rst_n       ( rst_n         ),
    .start_i     ( stream_start  ),
    .base_addr_i ( src_addr      ),
    .len_i       ( len           ),
    .req_o       ( src_req_o     ),
    .add_o       ( src_add_o     ),
    .gnt_i       ( src_gnt_i     ),
    .r_data_i    ( src_r_data_i  ),
    .r_valid_i   ( src_r_valid_i ),
    .tvalid_o    ( src_tvalid_o  ),
    .tdata_o     ( src_tdata_o   ),
    .tlast_o     ( src_tlast_o   ),
    .tready_i    ( src_tready_i  ),
    .done_o      ( src_done      )
  );

  hwce_stream_sink sink_inst (
    .clk_gated   ( clk_gated    ),
    .rst_n       ( rst_n        ),
    .start_i     ( stream_start ),
    .base_addr_i ( dst_addr     ),
    .len_i       ( len          ),
    .tvalid_i    ( snk_tvalid_i ),
    .tdata_i     ( snk_tdata_i  ),
    .tlast_i     ( snk_tlast_i  ),
    .tready_o    ( snk_tready_o ),
    .req_o       ( snk_req_o    ),
    .add_o       ( snk_add_o    ),
    .data_o      ( snk_data_o   ),
    .gnt_i       ( snk_gnt_i    ),
    .done_o      ( snk_done     ),
    .frame_err_o ( frame_err    )
  );

endmodule

/* src/hwce_job_fsm.sv */
// hwce_lite job sequencer
// starts both streams, waits for their done pulses, drives busy and working
`timescale 1ns/10ps

module hwce_job_fsm import hwce_pkg::*; (
  input  logic clk_gated,
  input  logic rst_n,
  input  logic job_start_i,
  input  logic src_done_i,
  input  logic snk_done_i,
  output logic stream_start_o,
  output logic busy_o,
  output logic working_o,
  output logic job_done_o
);

  job_state_t state;
  logic       src_flag;
  logic       snk_flag;
  logic       busy_q;
  logic       both_done;

  // a done arriving this cycle counts as already seen
  assign both_done = (src_flag | src_done_i) & (snk_flag | snk_done_i);

  assign busy_o     = (state != IDLE);
  assign job_done_o = (state == FINISH);
  // clock gate stays open one cycle past busy
  assign working_o  = busy_o | busy_q;

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      state          <= IDLE;
      stream_start_o <= 1'b0;
      src_flag       <= 1'b0;
      snk_flag       <= 1'b0;
      busy_q         <= 1'b0;
    end else begin
      stream_start_o <= 1'b0;
      busy_q         <= busy_o;
      case (state)
        IDLE: begin
          if (job_start_i) begin
            state          <= RUN;
            stream_start_o <= 1'b1;
            src_flag       <= 1'b0;
            snk_flag       <= 1'b0;
          end
        end
        RUN: begin
          // remember each stream finishing
          if (src_done_i) src_flag <= 1'b1;
          if (snk_done_i) snk_flag <= 1'b1;
          if (both_done) state <= FINISH;
        end
        // single cycle, job_done high here
        FINISH:  state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* src/hwce_cfg_slave.sv */
// hwce_lite configuration target
// job registers, status readback, trigger decode and end-of-job event
`timescale 1ns/10ps

module hwce_cfg_slave import hwce_pkg::*; (
  input  logic            clk_gated,
  input  logic            rst_n,
  // config request
  input  logic            cfg_req_i,
  input  addr_t           cfg_add_i,
  input  logic            cfg_type_i,
  input  word_t           cfg_data_i,
  input  logic [ID_W-1:0] cfg_id_i,
  // config response
  output logic            cfg_gnt_o,
  output logic            cfg_r_valid_o,
  output word_t           cfg_r_data_o,
  output logic [ID_W-1:0] cfg_r_id_o,
  // engine status
  input  logic            busy_i,
  input  logic            job_done_i,
  input  logic            frame_err_i,
  // job control
  output logic            job_start_o,
  output addr_t           src_addr_o,
  output addr_t           dst_addr_o,
  output len_t            len_o,
  output logic            evt_interrupt_o
);

  logic [CFG_SEL_W-1:0] sel;
  logic                 wr_en;
  logic                 locked;
  word_t                rdata;

  // target never stalls
  assign cfg_gnt_o = 1'b1;

  // word index inside the register window
  assign sel   = cfg_add_i[CFG_SEL_W+1:2];
  assign wr_en = cfg_req_i & ~cfg_type_i;
  // job regs frozen from trigger until sequencer back to idle
  assign locked = busy_i | job_start_o;

  // read mux
  always_comb begin
    case (sel)
      REG_STATUS:   rdata = {{(DATA_W-2){1'b0}}, frame_err_i, busy_i};
      REG_SRC_ADDR: rdata = word_t'(src_addr_o);
      REG_DST_ADDR: rdata = word_t'(dst_addr_o);
      REG_LEN:      rdata = word_t'(len_o);
      default:      rdata = '0;
    endcase
  end

  // response one cycle after every request, ID echoed
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      cfg_r_valid_o <= 1'b0;
      cfg_r_data_o  <= '0;
      cfg_r_id_o    <= '0;
    end else begin
      cfg_r_valid_o <= cfg_req_i;
      if (cfg_req_i) begin
        cfg_r_id_o <= cfg_id_i;
        // writes answer with zero
        cfg_r_data_o <= cfg_type_i ? rdata : '0;
      end
    end
  end

  // job registers
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      src_addr_o <= '0;
      dst_addr_o <= '0;
      len_o      <= '0;
    end else if (wr_en && !locked) begin
      case (sel)
        REG_SRC_ADDR: src_addr_o <= addr_t'(cfg_data_i);
        REG_DST_ADDR: dst_addr_o <= addr_t'(cfg_data_i);
        REG_LEN:      len_o      <= cfg_data_i[LEN_W-1:0];
        default:      ;
      endcase
    end
  end

  // trigger pulse and event delay
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      job_start_o     <= 1'b0;
      evt_interrupt_o <= 1'b0;
    end else begin
      // empty jobs never start
      job_start_o     <= wr_en & (sel == REG_TRIGGER) & ~locked & (len_o != '0);
      evt_interrupt_o <= job_done_i;
    end
  end

endmodule

/* src/hwce_stream_sink.sv */
// hwce_lite sink stream
// takes LEN beats from the engine, writes them to memory, checks tlast framing
`timescale 1ns/10ps

module hwce_stream_sink import hwce_pkg::*; (
  input  logic  clk_gated,
  input  logic  rst_n,
  input  logic  start_i,
  input  addr_t base_addr_i,
  input  len_t  len_i,
  // incoming stream
  input  logic  tvalid_i,
  input  word_t tdata_i,
  input  logic  tlast_i,
  output logic  tready_o,
  // memory write port
  output logic  req_o,
  output addr_t add_o,
  output word_t data_o,
  input  logic  gnt_i,
  output logic  done_o,
  output logic  frame_err_o
);

  logic       active;
  addr_t      base_q;
  len_t       len_q;
  len_t       last_idx;
  len_t       acc_cnt;
  len_t       wr_cnt;
  logic       accept;
  logic       wgnt;
  logic       wr_last;
  logic       fifo_empty;
  logic       fifo_full;
  sink_beat_t beat_in;
  sink_beat_t head;

  // stop taking beats once LEN are in, or no room
  assign tready_o = active & (acc_cnt != len_q) & ~fifo_full;
  assign accept   = tvalid_i & tready_o;
  assign beat_in  = {tlast_i, tdata_i};

  // head of fifo goes out, held until granted
  assign req_o   = active & ~fifo_empty;
  assign wgnt    = req_o & gnt_i;
  assign add_o   = base_q + addr_t'({wr_cnt, 2'b00});
  assign data_o  = head.data;
  assign wr_last = (wr_cnt == last_idx);

  always_ff @(posedge clk_gated) begin
    if (start_i) base_q <= base_addr_i;
  end

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      active      <= 1'b0;
      len_q       <= '0;
      last_idx    <= '0;
      acc_cnt     <= '0;
      wr_cnt      <= '0;
      done_o      <= 1'b0;
      frame_err_o <= 1'b0;
    end else begin
      done_o <= wgnt & wr_last;
      if (start_i) begin
        active      <= 1'b1;
        len_q       <= len_i;
        last_idx    <= len_i - 1'b1;
        acc_cnt     <= '0;
        wr_cnt      <= '0;
        frame_err_o <= 1'b0;
      end else begin
        if (accept) acc_cnt <= acc_cnt + 1'b1;
        if (wgnt) begin
          wr_cnt <= wr_cnt + 1'b1;
          // tlast must sit on the final beat only, sticky until next start
          if (head.last != wr_last) frame_err_o <= 1'b1;
          if (wr_last) active <= 1'b0;
        end
      end
    end
  end

  hwce_stream_fifo #(
    .payload_t ( sink_beat_t )
  ) snk_fifo_inst (
    .clk_gated ( clk_gated   ),
    .rst_n     ( rst_n       ),
    .push_i    ( accept      ),
    .data_i    ( beat_in     ),
    .pop_i     ( wgnt        ),
    .data_o    ( head        ),
    .empty_o   ( fifo_empty  ),
    .full_o    ( fifo_full   ),
    .count_o   (             )
  );

endmodule

/* src/hwce_stream_source.sv */
// hwce_lite source stream
// reads LEN words from cluster memory, several in flight, out as valid/ready
`timescale 1ns/10ps

module hwce_stream_source import hwce_pkg::*; (
  input  logic  clk_gated,
  input  logic  rst_n,
  input  logic  start_i,
  input  addr_t base_addr_i,
  input  len_t  len_i,
  // memory read port
  output logic  req_o,
  output addr_t add_o,
  input  logic  gnt_i,
  input  word_t r_data_i,
  input  logic  r_valid_i,
  // outgoing stream
  output logic  tvalid_o,
  output word_t tdata_o,
  output logic  tlast_o,
  input  logic  tready_i,
  output logic  done_o
);

  logic                  active;
  addr_t                 rd_addr;
  len_t                  len_q;
  len_t                  last_idx;
  len_t                  issue_cnt;
  len_t                  out_cnt;
  logic [FIFO_CNT_W-1:0] inflight;
  logic [FIFO_CNT_W-1:0] fifo_cnt;
  logic [FIFO_CNT_W:0]   pending;
  logic                  req_q;
  logic                  gnt_m;
  logic                  rvalid_m;
  logic                  fifo_empty;
  logic                  pop;

  // words stored plus words still coming back
  assign pending = {1'b0, fifo_cnt} + {1'b0, inflight};
  // only ask when a slot is reserved for the answer
  assign req_o   = active & (issue_cnt != len_q) & (pending < (FIFO_CNT_W+1)'(FIFO_DEPTH));
  assign add_o   = rd_addr;

  // ignore grants and responses not meant for us
  assign gnt_m    = gnt_i & req_o;
  assign rvalid_m = r_valid_i & req_q;

  // stream side
  assign tvalid_o = ~fifo_empty;
  assign tlast_o  = (out_cnt == last_idx);
  assign pop      = tvalid_o & tready_i;

  // read address, advances per grant
  always_ff @(posedge clk_gated) begin
    if (start_i) rd_addr <= base_addr_i;
    else if (gnt_m) rd_addr <= rd_addr + ADDR_W'(4);
  end

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      active    <= 1'b0;
      len_q     <= '0;
      last_idx  <= '0;
      issue_cnt <= '0;
      out_cnt   <= '0;
      inflight  <= '0;
      req_q     <= 1'b0;
      done_o    <= 1'b0;
    end else begin
      req_q    <= req_o;
      inflight <= inflight + FIFO_CNT_W'(gnt_m) - FIFO_CNT_W'(rvalid_m);
      // pulse once the tlast word has left
      done_o   <= pop & tlast_o;
      if (start_i) begin
        active    <= 1'b1;
        len_q     <= len_i;
        last_idx  <= len_i - 1'b1;
        issue_cnt <= '0;
        out_cnt   <= '0;
      end else begin
        if (gnt_m) issue_cnt <= issue_cnt + 1'b1;
        if (pop) begin
          out_cnt <= out_cnt + 1'b1;
          if (tlast_o) active <= 1'b0;
        end
      end
    end
  end

  // read data lands here the cycle after the grant
  hwce_stream_fifo #(
    .payload_t ( word_t     )
  ) src_fifo_inst (
    .clk_gated ( clk_gated  ),
    .rst_n     ( rst_n      ),
    .push_i    ( rvalid_m   ),
    .data_i    ( r_data_i   ),
    .pop_i     ( pop        ),
    .data_o    ( tdata_o    ),
    .empty_o   ( fifo_empty ),
    .full_o    (            ),
    .count_o   ( fifo_cnt   )
  );

endmodule

/* src/hwce_stream_fifo.sv */
// hwce_lite stream FIFO
// circular buffer of FIFO_DEPTH entries, payload type chosen per instance
`timescale 1ns/10ps

module hwce_stream_fifo import hwce_pkg::*; #(
  parameter type payload_t = word_t
) (
  input  logic                  clk_gated,
  input  logic                  rst_n,
  input  logic                  push_i,
  input  payload_t              data_i,
  input  logic                  pop_i,
  output payload_t              data_o,
  output logic                  empty_o,
  output logic                  full_o,
  output logic [FIFO_CNT_W-1:0] count_o
);

  payload_t              mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] cnt;
  logic                  do_push;
  logic                  do_pop;

  assign empty_o = (cnt == '0);
  assign full_o  = (cnt == FIFO_CNT_W'(FIFO_DEPTH));
  assign count_o = cnt;
  // overflow and underflow requests dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  // head always visible
  assign data_o  = mem[rd_ptr];

  // storage
  always_ff @(posedge clk_gated) begin
    if (do_push) mem[wr_ptr] <= data_i;
  end

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      // explicit wrap, depth need not be a power of two
      if (do_push) wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      cnt <= cnt + FIFO_CNT_W'(do_push) - FIFO_CNT_W'(do_pop);
    end
  end

endmodule

/* src/hwce_pkg.sv */
// hwce_lite shared definitions
// bus widths, register map, sequencer states and stream payload types
package hwce_pkg;

  // cluster memory and config bus widths
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int ID_W      = 16;
  // job length in words
  localparam int LEN_W     = 16;
  // register select, taken from address bits 4..2
  localparam int CFG_SEL_W = 3;

  // stream fifo sizing
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  // occupancy needs one extra state for full
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // register map, one word each
  localparam logic [CFG_SEL_W-1:0] REG_TRIGGER  = 3'd0;
  localparam logic [CFG_SEL_W-1:0] REG_STATUS   = 3'd1;
  localparam logic [CFG_SEL_W-1:0] REG_SRC_ADDR = 3'd2;
  localparam logic [CFG_SEL_W-1:0] REG_DST_ADDR = 3'd3;
  localparam logic [CFG_SEL_W-1:0] REG_LEN      = 3'd4;

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LEN_W-1:0]  len_t;

  // sink fifo entry, data word plus its tlast
  typedef struct packed {
    logic  last;
    word_t data;
  } sink_beat_t;

  // job sequencer
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FINISH
  } job_state_t;

endpackage
